// File: run_sim.sh
#!/bin/sh
# builds the umem testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing -Wno-fatal -f umem.f --top-module umem_tb \
  -Mdir "$BUILD_DIR" -o umem_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$BUILD_DIR/umem_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "Regression passed" "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1

// File: source/fetch_align.sv
`default_nettype none

module fetch_align (
  input  logic                clk,
  input  logic                fetch_issue,
  input  umem_pkg::addr_t     fetch_addr,
  output umem_pkg::bank_idx_t even_idx,
  output umem_pkg::bank_idx_t odd_idx,
  input  umem_pkg::word_t     even_word,
  input  umem_pkg::word_t     odd_word,
  output umem_pkg::word_t     instr
);

  umem_pkg::word_idx_t w_idx;
  umem_pkg::word_idx_t next_idx;
  logic                half_r; // pc bit 1 of the fetch in flight
  logic                w_odd_r; // word w sits in the odd bank
  umem_pkg::word_t     lo_word;
  umem_pkg::word_t     hi_word;

  assign w_idx    = fetch_addr[11:2]; // upper address bits ignored
  assign next_idx = w_idx + 1'b1; // last word wraps to word 0

  // an even w shares its row with w+1, an odd w pairs with the next row
  assign odd_idx  = w_idx[9:1];
  assign even_idx = next_idx[9:1];

  always_ff @(posedge clk)
  begin
    if (fetch_issue)
    begin
      half_r  <= fetch_addr[1];
      w_odd_r <= w_idx[0];
    end
  end

  assign lo_word = w_odd_r ? odd_word : even_word; // word w
  assign hi_word = w_odd_r ? even_word : odd_word; // word w+1
  assign instr   = half_r ? {hi_word[15:0], lo_word[31:16]} : lo_word;

endmodule

`default_nettype wire

// File: source/load_extract.sv
`default_nettype none

module load_extract (
  input  logic            clk,
  mem_port_if.datapath    port,
  input  umem_pkg::word_t rdata,
  output umem_pkg::word_t load_data
);

  logic [1:0]       offset_r;
  umem_pkg::width_t width_r;
  logic             signed_r;
  logic [7:0]       byte_sel;
  logic [15:0]      half_sel;

  // attributes follow the load to the cycle its word comes back
  always_ff @(posedge clk)
  begin
    if (port.issue && !port.write)
    begin
      offset_r <= port.addr[1:0];
      width_r  <= port.width;
      signed_r <= port.signed_ld;
    end
  end

  assign byte_sel = rdata[{offset_r, 3'b000} +: 8];
  assign half_sel = offset_r[1] ? rdata[31:16] : rdata[15:0];

  always_comb
  begin
    case (width_r)
      umem_pkg::WIDTH_BYTE:
        load_data = {{24{signed_r & byte_sel[7]}}, byte_sel};
      umem_pkg::WIDTH_HALF:
        load_data = {{16{signed_r & half_sel[15]}}, half_sel};
      umem_pkg::WIDTH_WORD:
        load_data = rdata;
      default:
        load_data = '0; // invalid width reads zero
    endcase
  end

endmodule

`default_nettype wire

// File: source/mem_array.sv
`default_nettype none

module mem_array (
  input  logic                clk,
  input  logic                rst_n,
  mem_port_if.datapath        port,
  input  umem_pkg::mask_t     wmask,
  input  umem_pkg::word_t     wdata_lanes,
  input  umem_pkg::bank_idx_t even_idx,
  input  umem_pkg::bank_idx_t odd_idx,
  output umem_pkg::word_t     rdata,
  output umem_pkg::word_t     even_word,
  output umem_pkg::word_t     odd_word
);

  umem_pkg::word_t     even_bank [umem_pkg::MEM_WORDS/2];
  umem_pkg::word_t     odd_bank  [umem_pkg::MEM_WORDS/2];
  umem_pkg::word_idx_t d_idx;
  umem_pkg::bank_idx_t d_bank_idx;
  logic                d_odd;
  logic                do_write;

  assign d_idx      = port.addr[11:2]; // upper address bits ignored
  assign d_odd      = d_idx[0];
  assign d_bank_idx = d_idx[9:1];
  assign do_write   = port.issue && port.write;

  // all three reads see the contents from before this cycle's write
  always_ff @(posedge clk)
  begin
    rdata     <= d_odd ? odd_bank[d_bank_idx] : even_bank[d_bank_idx];
    even_word <= even_bank[even_idx];
    odd_word  <= odd_bank[odd_idx];
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < umem_pkg::MEM_WORDS/2; i++)
      begin
        even_bank[i] <= '0;
        odd_bank[i]  <= '0;
      end
    end
    else if (do_write)
    begin
      for (int b = 0; b < $bits(umem_pkg::mask_t); b++)
      begin
        if (wmask[b])
        begin
          if (d_odd)
            odd_bank[d_bank_idx][8*b +: 8] <= wdata_lanes[8*b +: 8];
          else
            even_bank[d_bank_idx][8*b +: 8] <= wdata_lanes[8*b +: 8];
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: source/mem_ctrl.sv
`default_nettype none

module mem_ctrl (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             dreq_valid,
  input  logic             dreq_write,
  input  logic             dreq_signed,
  input  umem_pkg::width_t dreq_width,
  input  umem_pkg::addr_t  dreq_addr,
  input  umem_pkg::word_t  dreq_wdata,
  input  logic             fetch_valid,
  input  umem_pkg::addr_t  fetch_pc,
  output logic             dreq_credit,
  output logic             fetch_credit,
  output logic             dresp_valid,
  output logic             instr_valid,
  mem_port_if.control      port,
  output logic             fetch_issue,
  output umem_pkg::addr_t  fetch_addr
);

  logic             d_write_q  [umem_pkg::QUEUE_DEPTH];
  logic             d_signed_q [umem_pkg::QUEUE_DEPTH];
  umem_pkg::width_t d_width_q  [umem_pkg::QUEUE_DEPTH];
  umem_pkg::addr_t  d_addr_q   [umem_pkg::QUEUE_DEPTH];
  umem_pkg::word_t  d_wdata_q  [umem_pkg::QUEUE_DEPTH];
  umem_pkg::addr_t  f_pc_q     [umem_pkg::QUEUE_DEPTH];
  umem_pkg::qptr_t  d_wr_ptr, d_rd_ptr, f_wr_ptr, f_rd_ptr;
  umem_pkg::qcnt_t  d_count, f_count;
  logic             d_issue;

  assign d_issue     = (d_count != '0); // head issues every cycle
  assign fetch_issue = (f_count != '0);

  assign port.issue     = d_issue;
  assign port.write     = d_write_q[d_rd_ptr];
  assign port.signed_ld = d_signed_q[d_rd_ptr];
  assign port.width     = d_width_q[d_rd_ptr];
  assign port.addr      = d_addr_q[d_rd_ptr];
  assign port.wdata     = d_wdata_q[d_rd_ptr];
  assign fetch_addr     = f_pc_q[f_rd_ptr];

  assign dreq_credit  = d_issue; // one credit back per issue
  assign fetch_credit = fetch_issue;

  always_ff @(posedge clk)
  begin
    if (dreq_valid)
    begin
      d_write_q[d_wr_ptr]  <= dreq_write;
      d_signed_q[d_wr_ptr] <= dreq_signed;
      d_width_q[d_wr_ptr]  <= dreq_width;
      d_addr_q[d_wr_ptr]   <= dreq_addr;
      d_wdata_q[d_wr_ptr]  <= dreq_wdata;
    end
    if (fetch_valid)
      f_pc_q[f_wr_ptr] <= fetch_pc;
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      d_wr_ptr    <= '0;
      d_rd_ptr    <= '0;
      d_count     <= '0;
      f_wr_ptr    <= '0;
      f_rd_ptr    <= '0;
      f_count     <= '0;
      dresp_valid <= 1'b0;
      instr_valid <= 1'b0;
    end
    else
    begin
      if (dreq_valid)
        d_wr_ptr <= (d_wr_ptr == umem_pkg::QPTR_LAST) ? '0 : d_wr_ptr + 1'b1;
      if (d_issue)
        d_rd_ptr <= (d_rd_ptr == umem_pkg::QPTR_LAST) ? '0 : d_rd_ptr + 1'b1;
      if (fetch_valid)
        f_wr_ptr <= (f_wr_ptr == umem_pkg::QPTR_LAST) ? '0 : f_wr_ptr + 1'b1;
      if (fetch_issue)
        f_rd_ptr <= (f_rd_ptr == umem_pkg::QPTR_LAST) ? '0 : f_rd_ptr + 1'b1;
      d_count     <= d_count + dreq_valid - d_issue;
      f_count     <= f_count + fetch_valid - fetch_issue;
      dresp_valid <= d_issue && !d_write_q[d_rd_ptr]; // stores give no response
      instr_valid <= fetch_issue;
    end
  end

endmodule

`default_nettype wire

// File: source/mem_port_if.sv
`default_nettype none

// one data access, issued from the queue head
interface mem_port_if;

  logic issue; // valid for one cycle per access
  logic write;
  logic signed_ld; // sign-extend a load result
  umem_pkg::width_t width;
  umem_pkg::addr_t addr;
  umem_pkg::word_t wdata;

  modport control (
    output issue,
    output write,
    output signed_ld,
    output width,
    output addr,
    output wdata
  );

  modport datapath (
    input issue,
    input write,
    input signed_ld,
    input width,
    input addr,
    input wdata
  );

endinterface

`default_nettype wire

// File: source/store_align.sv
`default_nettype none

module store_align (
  mem_port_if.datapath    port,
  output umem_pkg::mask_t wmask,
  output umem_pkg::word_t wdata_lanes
);

  logic [1:0] offset;

  assign offset = port.addr[1:0];

  always_comb
  begin
    case (port.width)
      umem_pkg::WIDTH_BYTE:
      begin
        wmask       = umem_pkg::mask_t'(4'b0001 << offset);
        wdata_lanes = {4{port.wdata[7:0]}}; // byte copied to every lane
      end
      umem_pkg::WIDTH_HALF:
      begin
        wmask       = offset[1] ? 4'b1100 : 4'b0011; // offset bit 0 ignored
        wdata_lanes = {2{port.wdata[15:0]}};
      end
      umem_pkg::WIDTH_WORD:
      begin
        wmask       = 4'b1111;
        wdata_lanes = port.wdata;
      end
      default:
      begin
        wmask       = 4'b0000; // invalid width writes nothing
        wdata_lanes = port.wdata;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: source/umem_pkg.sv
`default_nettype none

package umem_pkg;

  typedef logic [31:0] word_t; // data or instruction word
  typedef logic [31:0] addr_t; // byte address from the core

  localparam int MEM_WORDS = 1024; // 4 KB

  typedef logic [$clog2(MEM_WORDS)-1:0] word_idx_t;
  typedef logic [$clog2(MEM_WORDS)-2:0] bank_idx_t; // half the words per bank
  typedef logic [1:0] width_t;
  typedef logic [3:0] mask_t; // one bit per byte lane

  localparam width_t WIDTH_BYTE = 2'd0;
  localparam width_t WIDTH_HALF = 2'd1;
  localparam width_t WIDTH_WORD = 2'd2; // code 3 is invalid

  // request queue per port, also the credits a requester starts with
  localparam int QUEUE_DEPTH = 2;
  localparam int QPTR_W = $clog2(QUEUE_DEPTH);

  typedef logic [QPTR_W-1:0] qptr_t;
  typedef logic [QPTR_W:0] qcnt_t;

  localparam qptr_t QPTR_LAST = qptr_t'(QUEUE_DEPTH - 1);

endpackage

`default_nettype wire

// File: source/umem_top.sv
`default_nettype none

module umem_top (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             dreq_valid,
  input  logic             dreq_write,
  input  umem_pkg::width_t dreq_width,
  input  logic             dreq_signed,
  input  umem_pkg::addr_t  dreq_addr,
  input  umem_pkg::word_t  dreq_wdata,
  output logic             dreq_credit,
  output logic             dresp_valid,
  output umem_pkg::word_t  dresp_rdata,
  input  logic             fetch_valid,
  input  umem_pkg::addr_t  fetch_pc,
  output logic             fetch_credit,
  output logic             instr_valid,
  output umem_pkg::word_t  instr
);

  mem_port_if dport ();

  logic                fetch_issue;
  umem_pkg::addr_t     fetch_addr;
  umem_pkg::mask_t     wmask;
  umem_pkg::word_t     wdata_lanes;
  umem_pkg::word_t     rdata;
  umem_pkg::bank_idx_t even_idx, odd_idx;
  umem_pkg::word_t     even_word, odd_word;

  mem_ctrl u_ctrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .dreq_valid   (dreq_valid),
    .dreq_write   (dreq_write),
    .dreq_signed  (dreq_signed),
    .dreq_width   (dreq_width),
    .dreq_addr    (dreq_addr),
    .dreq_wdata   (dreq_wdata),
    .fetch_valid  (fetch_valid),
    .fetch_pc     (fetch_pc),
    .dreq_credit  (dreq_credit),
    .fetch_credit (fetch_credit),
    .dresp_valid  (dresp_valid),
    .instr_valid  (instr_valid),
    .port         (dport.control),
    .fetch_issue  (fetch_issue),
    .fetch_addr   (fetch_addr)
  );

  store_align u_store (
    .port        (dport.datapath),
    .wmask       (wmask),
    .wdata_lanes (wdata_lanes)
  );

  mem_array u_array (
    .clk         (clk),
    .rst_n       (rst_n),
    .port        (dport.datapath),
    .wmask       (wmask),
    .wdata_lanes (wdata_lanes),
    .even_idx    (even_idx),
    .odd_idx     (odd_idx),
    .rdata       (rdata),
    .even_word   (even_word),
    .odd_word    (odd_word)
  );

  load_extract u_load (
    .clk       (clk),
    .port      (dport.datapath),
    .rdata     (rdata),
    .load_data (dresp_rdata)
  );

  fetch_align u_fetch (
    .clk         (clk),
    .fetch_issue (fetch_issue),
    .fetch_addr  (fetch_addr),
    .even_idx    (even_idx),
    .odd_idx     (odd_idx),
    .even_word   (even_word),
    .odd_word    (odd_word),
    .instr       (instr)
  );

endmodule

`default_nettype wire

// File: tb/umem_checker.sv
`default_nettype none

module umem_checker (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             dreq_valid,
  input  logic             dreq_write,
  input  umem_pkg::width_t dreq_width,
  input  logic             dreq_signed,
  input  umem_pkg::addr_t  dreq_addr,
  input  umem_pkg::word_t  dreq_wdata,
  input  logic             dreq_credit,
  input  logic             dresp_valid,
  input  umem_pkg::word_t  dresp_rdata,
  input  logic             fetch_valid,
  input  umem_pkg::addr_t  fetch_pc,
  input  logic             fetch_credit,
  input  logic             instr_valid,
  input  umem_pkg::word_t  instr,
  output int               errors,
  output int               checks,
  output int               pending
);

  umem_pkg::word_t shadow [umem_pkg::MEM_WORDS]; // expected memory contents
  umem_pkg::word_t d_exp_val [$];
  int              d_exp_due [$]; // cycle the load response must show up
  umem_pkg::word_t f_exp_val [$];
  int              f_exp_due [$];
  int              cycle;
  logic            d_acc_prev;
  logic            f_acc_prev;
  umem_pkg::word_t expected;

  task automatic compare_word(input string name, input umem_pkg::word_t exp_v,
                              input umem_pkg::word_t act_v);
    checks++;
    if (act_v !== exp_v)
    begin
      errors++;
      $display("[ERROR] %s expected %08h actual %08h at cycle %0d", name, exp_v, act_v, cycle);
    end
  endtask

  task automatic compare_bit(input string name, input logic exp_v, input logic act_v);
    checks++;
    if (act_v !== exp_v)
    begin
      errors++;
      $display("[ERROR] %s expected %0h actual %0h at cycle %0d", name, exp_v, act_v, cycle);
    end
  endtask

  task automatic report(input string what);
    errors++;
    $display("error: %s at cycle %0d", what, cycle);
  endtask

  task automatic apply_store(input umem_pkg::width_t w, input umem_pkg::addr_t a,
                             input umem_pkg::word_t data);
    logic [9:0] idx;
    idx = a[11:2]; // bits above 4 KB do not matter
    case (w)
      umem_pkg::WIDTH_BYTE:
        shadow[idx][8*a[1:0] +: 8] = data[7:0];
      umem_pkg::WIDTH_HALF:
        if (a[1])
          shadow[idx][31:16] = data[15:0];
        else
          shadow[idx][15:0] = data[15:0];
      umem_pkg::WIDTH_WORD:
        shadow[idx] = data;
      default:
        ; // code 3 leaves memory alone
    endcase
  endtask

  // expected load or fetch result from the shadow memory
  function automatic umem_pkg::word_t predict(input logic is_fetch, input umem_pkg::width_t w,
                                              input logic sgn, input umem_pkg::addr_t a);
    logic [9:0]      idx;
    logic [9:0]      next_idx;
    logic [63:0]     pair;
    umem_pkg::word_t word;
    logic [7:0]      b;
    logic [15:0]     h;
    idx      = a[11:2];
    next_idx = idx + 10'd1; // last word wraps to word 0
    word     = shadow[idx];
    pair     = {shadow[next_idx], word}; // instruction may straddle two words
    if (is_fetch)
      return 32'(pair >> (16 * a[1]));
    b = 8'(word >> (8 * a[1:0]));
    h = 16'(word >> (16 * a[1]));
    case (w)
      umem_pkg::WIDTH_BYTE:
        return (sgn && b[7]) ? 32'(b) - 32'h100 : 32'(b);
      umem_pkg::WIDTH_HALF:
        return (sgn && h[15]) ? 32'(h) - 32'h1_0000 : 32'(h);
      umem_pkg::WIDTH_WORD:
        return word;
      default:
        return '0;
    endcase
  endfunction

  always @(posedge clk)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < umem_pkg::MEM_WORDS; i++)
        shadow[i] = '0; // whole memory clears on reset
      d_exp_val.delete();
      d_exp_due.delete();
      f_exp_val.delete();
      f_exp_due.delete();
      d_acc_prev = 1'b0;
      f_acc_prev = 1'b0;
      errors     = 0;
      checks     = 0;
      cycle      = 0;
    end
    else
    begin
      cycle++;
      compare_bit("dreq_credit", d_acc_prev, dreq_credit); // one cycle after intake
      compare_bit("fetch_credit", f_acc_prev, fetch_credit);
      if (d_exp_due.size() != 0 && d_exp_due[0] == cycle)
      begin
        expected = d_exp_val.pop_front();
        void'(d_exp_due.pop_front());
        if (dresp_valid)
          compare_word("dresp_rdata", expected, dresp_rdata);
        else
          report("load response missing two cycles after acceptance");
      end
      else if (dresp_valid)
        report("load response arrived with nothing expected");
      if (f_exp_due.size() != 0 && f_exp_due[0] == cycle)
      begin
        expected = f_exp_val.pop_front();
        void'(f_exp_due.pop_front());
        if (instr_valid)
          compare_word("instr", expected, instr);
        else
          report("instruction missing two cycles after acceptance");
      end
      else if (instr_valid)
        report("instruction arrived with nothing expected");
      // fetch sees memory from before a store taken at the same edge
      if (fetch_valid)
      begin
        f_exp_val.push_back(predict(1'b1, umem_pkg::WIDTH_WORD, 1'b0, fetch_pc));
        f_exp_due.push_back(cycle + 2);
      end
      if (dreq_valid && dreq_write)
        apply_store(dreq_width, dreq_addr, dreq_wdata);
      else if (dreq_valid)
      begin
        d_exp_val.push_back(predict(1'b0, dreq_width, dreq_signed, dreq_addr));
        d_exp_due.push_back(cycle + 2);
      end
      d_acc_prev = dreq_valid;
      f_acc_prev = fetch_valid;
    end
    pending = d_exp_due.size() + f_exp_due.size();
  end

endmodule

`default_nettype wire

// File: tb/umem_tb.sv
`default_nettype none

module umem_tb;

  localparam int T1_REQ       = 16;
  localparam int T2_REQ       = 111;
  localparam int T3_REQ       = 20;
  localparam int T4_REQ       = 64;
  localparam int T5_REQ       = 16;
  localparam int T6_REQ       = 401;
  localparam int PLANNED_REQ  = T1_REQ + T2_REQ + T3_REQ + T4_REQ + T5_REQ + T6_REQ;
  localparam int LIMIT_CYCLES = 10 + PLANNED_REQ * 4 + 200; // reset, 4 per request, margin

  // word-aligned and 2-mod-4 fetches, last word wraps, high bits ignored
  localparam umem_pkg::addr_t FETCH_PCS [8] = '{
    32'h0000_0000, 32'h0000_0002, 32'h0000_0004, 32'h0000_0FF8,
    32'h0000_0FFA, 32'h0000_0FFC, 32'h0000_0FFE, 32'hFFFF_FFFE
  };

  logic             clk;
  logic             rst_n;
  logic             dreq_valid;
  logic             dreq_write;
  umem_pkg::width_t dreq_width;
  logic             dreq_signed;
  umem_pkg::addr_t  dreq_addr;
  umem_pkg::word_t  dreq_wdata;
  logic             dreq_credit;
  logic             dresp_valid;
  umem_pkg::word_t  dresp_rdata;
  logic             fetch_valid;
  umem_pkg::addr_t  fetch_pc;
  logic             fetch_credit;
  logic             instr_valid;
  umem_pkg::word_t  instr;
  int               chk_errors, chk_checks, chk_pending;
  int               d_spent, d_returned, f_spent, f_returned;
  int               tb_errors, stalls, failed_tests, err_mark;
  logic [31:0]      rng;

  umem_top uut (
    .clk          (clk),
    .rst_n        (rst_n),
    .dreq_valid   (dreq_valid),
    .dreq_write   (dreq_write),
    .dreq_width   (dreq_width),
    .dreq_signed  (dreq_signed),
    .dreq_addr    (dreq_addr),
    .dreq_wdata   (dreq_wdata),
    .dreq_credit  (dreq_credit),
    .dresp_valid  (dresp_valid),
    .dresp_rdata  (dresp_rdata),
    .fetch_valid  (fetch_valid),
    .fetch_pc     (fetch_pc),
    .fetch_credit (fetch_credit),
    .instr_valid  (instr_valid),
    .instr        (instr)
  );

  umem_checker chk (.*, .errors(chk_errors), .checks(chk_checks), .pending(chk_pending));

  always #10 clk = ~clk;

  always @(posedge clk)
  begin
    if (!rst_n)
    begin
      d_returned <= 0;
      f_returned <= 0;
    end
    else
    begin
      if (dreq_credit)
        d_returned <= d_returned + 1;
      if (fetch_credit)
        f_returned <= f_returned + 1;
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  task automatic draw(output logic [31:0] v);
    rng = xorshift32(rng);
    v   = rng;
  endtask

  function automatic int data_credits();
    return umem_pkg::QUEUE_DEPTH - d_spent + d_returned;
  endfunction

  function automatic int fetch_credits();
    return umem_pkg::QUEUE_DEPTH - f_spent + f_returned;
  endfunction

  function automatic umem_pkg::addr_t align(input umem_pkg::addr_t a, input umem_pkg::width_t w);
    if (w == umem_pkg::WIDTH_BYTE)
      return a;
    if (w == umem_pkg::WIDTH_HALF)
      return {a[31:1], 1'b0};
    return {a[31:2], 2'b00};
  endfunction

  // words 1008..1023 and 0..15, so traffic overlaps and crosses the wrap
  function automatic umem_pkg::addr_t window_addr(input logic [31:0] r);
    logic [9:0] idx;
    idx = 10'd1008 + 10'(r[8:4]);
    return {r[31:12], idx, r[1:0]};
  endfunction

  // one falling-edge slot; valids drop again at the next falling edge
  task automatic drive_cycle(input logic d_en, input logic wr, input umem_pkg::width_t w,
                             input logic sgn, input umem_pkg::addr_t a,
                             input umem_pkg::word_t wd, input logic f_en,
                             input umem_pkg::addr_t pc);
    while ((d_en && data_credits() == 0) || (f_en && fetch_credits() == 0))
    begin
      stalls++;
      @(negedge clk);
    end
    dreq_valid  = d_en;
    dreq_write  = wr;
    dreq_width  = w;
    dreq_signed = sgn;
    dreq_addr   = a;
    dreq_wdata  = wd;
    fetch_valid = f_en;
    fetch_pc    = pc;
    if (d_en)
      d_spent++;
    if (f_en)
      f_spent++;
    @(negedge clk);
    dreq_valid  = 1'b0;
    fetch_valid = 1'b0;
  endtask

  task automatic load_req(input umem_pkg::width_t w, input logic sgn, input umem_pkg::addr_t a);
    drive_cycle(1'b1, 1'b0, w, sgn, a, '0, 1'b0, '0);
  endtask

  task automatic store_req(input umem_pkg::width_t w, input umem_pkg::addr_t a,
                           input umem_pkg::word_t wd);
    drive_cycle(1'b1, 1'b1, w, 1'b0, a, wd, 1'b0, '0);
  endtask

  task automatic fetch_req(input umem_pkg::addr_t pc);
    drive_cycle(1'b0, 1'b0, umem_pkg::WIDTH_WORD, 1'b0, '0, '0, 1'b1, pc);
  endtask

  task automatic drain();
    while (chk_pending != 0 || data_credits() != umem_pkg::QUEUE_DEPTH ||
           fetch_credits() != umem_pkg::QUEUE_DEPTH)
      @(negedge clk);
  endtask

  task automatic close_test(input int num, input string name);
    int errs;
    drain();
    errs = chk_errors + tb_errors - err_mark;
    if (errs == 0)
      $display("test %0d %s: ok", num, name);
    else
    begin
      failed_tests++;
      $display("test %0d %s: FAILED with %0d errors", num, name, errs);
    end
    err_mark = chk_errors + tb_errors;
  endtask

  initial
  begin
    #(LIMIT_CYCLES * 20);
    $display("timeout: run did not finish within %0d cycles", LIMIT_CYCLES);
    $display("Regression failed");
    $finish;
  end

  initial
  begin
    logic [31:0]      r;
    logic [31:0]      a;
    logic [31:0]      wd;
    logic [31:0]      pc;
    umem_pkg::width_t w;
    logic             d_en;
    logic             f_en;
    int               count;
    int               total_errors;
    clk          = 1'b0;
    rst_n        = 1'b0;
    dreq_valid   = 1'b0;
    dreq_write   = 1'b0;
    dreq_width   = umem_pkg::WIDTH_BYTE;
    dreq_signed  = 1'b0;
    dreq_addr    = '0;
    dreq_wdata   = '0;
    fetch_valid  = 1'b0;
    fetch_pc     = '0;
    d_spent      = 0;
    f_spent      = 0;
    tb_errors    = 0;
    stalls       = 0;
    failed_tests = 0;
    err_mark     = 0;
    rng          = 32'd55155;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    repeat (4) @(negedge clk); // idle, outputs must stay low
    for (int i = 0; i < 8; i++)
    begin
      draw(r);
      draw(a);
      draw(pc);
      w = umem_pkg::width_t'(r[7:0] % 8'd3);
      drive_cycle(1'b1, 1'b0, w, r[8], align(a, w), '0, 1'b1, {pc[31:1], 1'b0});
    end
    close_test(1, "reset_reads_zero");

    store_req(umem_pkg::WIDTH_WORD, 32'h0000_0100, 32'hA5A5_5A5A);
    store_req(2'd3, 32'h0000_0100, 32'hFFFF_FFFF); // invalid width
    load_req(umem_pkg::WIDTH_WORD, 1'b0, 32'h0000_0100);
    for (int i = 0; i < 12; i++)
    begin
      draw(a);
      draw(r);
      draw(wd);
      w = r[1:0];
      store_req(w, align(a, w), wd);
      for (int lw = 0; lw < 4; lw++)
        for (int s = 0; s < 2; s++)
          load_req(umem_pkg::width_t'(lw), s[0], align(a, umem_pkg::width_t'(lw)));
    end
    close_test(2, "store_load_widths");

    for (int i = 0; i < 12; i++)
    begin
      draw(r);
      draw(wd);
      if (i < 3)
        a = 32'(i) << 2; // words 0, 1 and 2
      else if (i < 5)
        a = 32'(1019 + i) << 2; // words 1022 and 1023
      else
        a = {20'h0, r[9:0], 2'b00};
      store_req(umem_pkg::WIDTH_WORD, a, wd);
    end
    for (int i = 0; i < 8; i++)
      fetch_req(FETCH_PCS[i]);
    close_test(3, "fetch_alignment");

    stalls = 0;
    for (int i = 0; i < 32; i++)
    begin
      draw(r);
      draw(a);
      draw(wd);
      draw(pc);
      w = umem_pkg::width_t'(r[7:0] % 8'd3);
      drive_cycle(1'b1, r[8], w, r[9], align(window_addr(a), w), wd, 1'b1,
                  align(window_addr(pc), umem_pkg::WIDTH_HALF));
    end
    if (stalls != 0)
    begin
      tb_errors++;
      $display("error: back-to-back requests stalled %0d cycles waiting for credit", stalls);
    end
    close_test(4, "back_to_back");

    for (int k = 0; k < 4; k++)
    begin
      draw(r);
      a = {20'h0, r[9:0], 2'b00};
      draw(wd);
      store_req(umem_pkg::WIDTH_WORD, a, wd);
      drive_cycle(1'b1, 1'b1, umem_pkg::WIDTH_WORD, 1'b0, a, ~wd, 1'b1, a); // fetch sees wd
      fetch_req(a); // now sees ~wd
    end
    close_test(5, "store_fetch_same_cycle");

    count = 0;
    while (count < 400)
    begin
      draw(r);
      draw(a);
      draw(wd);
      draw(pc);
      d_en = r[0] | r[1];
      f_en = r[2] | r[3];
      if (!d_en && !f_en)
        d_en = 1'b1;
      w = r[6:5];
      drive_cycle(d_en, r[4], w, r[7], align(window_addr(a), w), wd, f_en,
                  align(window_addr(pc), umem_pkg::WIDTH_HALF));
      count += int'(d_en) + int'(f_en);
    end
    close_test(6, "random_mixed");

    total_errors = chk_errors + tb_errors;
    $display("summary: 6 tests, %0d failed, %0d checks, %0d errors",
             failed_tests, chk_checks, total_errors);
    if (total_errors == 0 && failed_tests == 0 && chk_checks > 0)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: umem.f
source/umem_pkg.sv
source/mem_port_if.sv
source/mem_ctrl.sv
source/store_align.sv
source/load_extract.sv
source/fetch_align.sv
source/mem_array.sv
source/umem_top.sv
tb/umem_checker.sv
tb/umem_tb.sv
